//--- cache_line_adapter.f
source/line_pkg.sv
source/xfer_if.sv
source/burst_sequencer.sv
source/line_fill.sv
source/line_drain.sv
source/cache_line_adapter.sv
verif/burst_mem_model.sv
verif/cache_line_adapter_chk.sv
verif/cache_line_adapter_tb.sv

//--- Bender.yml
package:
  name: cache_line_adapter

sources:
  - files:
      - source/line_pkg.sv
      - source/xfer_if.sv
      - source/burst_sequencer.sv
      - source/line_fill.sv
      - source/line_drain.sv
      - source/cache_line_adapter.sv
  - target: test
    files:
      - verif/burst_mem_model.sv
      - verif/cache_line_adapter_chk.sv
      - verif/cache_line_adapter_tb.sv

//--- verif/cache_line_adapter_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cache_line_adapter_tb;
    import line_pkg::*;

    localparam int NUM_ROWS       = 10;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 64;
    localparam bit OP_READ        = 1'b0;
    localparam bit OP_WRITE       = 1'b1;

    typedef struct {
        string                 name;
        bit                    op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [31:0]           seed;  // Mixed into write data.
    } row_t;

    row_t stimulus [NUM_ROWS] = '{
        '{"fill_untouched", OP_READ,  32'h0000_2040, 32'h0},
        '{"write_a",        OP_WRITE, 32'h0000_1000, 32'h11},
        '{"read_a",         OP_READ,  32'h0000_1000, 32'h0},
        '{"write_b_offset", OP_WRITE, 32'h0000_1047, 32'h22},
        '{"read_b_alias",   OP_READ,  32'h0000_105f, 32'h0},
        '{"write_c",        OP_WRITE, 32'h8000_0020, 32'h33},
        '{"rewrite_a",      OP_WRITE, 32'h0000_1003, 32'h44},
        '{"read_c",         OP_READ,  32'h8000_003c, 32'h0},
        '{"read_a_again",   OP_READ,  32'h0000_1010, 32'h0},
        '{"fill_top_line",  OP_READ,  32'hffff_fff8, 32'h0}
    };

    logic                  clk = 1'b0;
    logic                  rst;
    logic [ADDR_WIDTH-1:0] dfp_addr;
    logic                  dfp_read;
    logic                  dfp_write;
    logic [LINE_WIDTH-1:0] dfp_wdata;
    logic [LINE_WIDTH-1:0] dfp_rdata;
    logic                  dfp_resp;
    logic [ADDR_WIDTH-1:0] bmem_addr;
    logic                  bmem_read;
    logic                  bmem_write;
    logic [BEAT_WIDTH-1:0] bmem_wdata;
    logic                  bmem_ready;
    logic [ADDR_WIDTH-1:0] bmem_raddr;
    logic [BEAT_WIDTH-1:0] bmem_rdata;
    logic                  bmem_rvalid;

    line_u       shadow [logic [ADDR_WIDTH-1:0]];  // Written lines by aligned address.
    logic [31:0] rng_state    = 32'he103;
    int          resp_count   = 0;
    int          strobe_count = 0;
    int          cycle_count  = 0;

    always #4 clk = ~clk;

    cache_line_adapter cache_line_adapter_inst (.*);

    burst_mem_model burst_mem_model_inst (.*);

    bind cache_line_adapter cache_line_adapter_chk chk_inst (
        .clk        (clk),
        .rst        (rst),
        .dfp_resp   (dfp_resp),
        .bmem_read  (bmem_read),
        .bmem_write (bmem_write),
        .bmem_addr  (bmem_addr)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Untouched memory returns each beat's own address.
    function automatic line_u fill_pattern(input logic [ADDR_WIDTH-1:0] base);
        line_u line;
        for (int k = 0; k < BEATS_PER_LINE; k++) begin
            line.beat[k] = BEAT_WIDTH'(base + ADDR_WIDTH'(k * BEAT_BYTES));
        end
        return line;
    endfunction

    task automatic build_write_line(input logic [31:0] seed, output line_u line);
        logic [31:0] upper;
        for (int k = 0; k < BEATS_PER_LINE; k++) begin
            rng_state    = xorshift32(rng_state);
            upper        = rng_state;
            rng_state    = xorshift32(rng_state);
            line.beat[k] = {upper, rng_state ^ seed};
        end
    endtask

    task automatic end_with_failure();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_line(input string name, input line_u expected, input line_u actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected.flat, actual.flat);
            end_with_failure();
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic run_row(input row_t row);
        logic [ADDR_WIDTH-1:0] base;
        line_u                 expected;
        line_u                 actual;
        int                    resp_before;
        base        = {row.addr[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        resp_before = resp_count;
        dfp_addr    = row.addr;
        if (row.op == OP_WRITE) begin
            build_write_line(row.seed, expected);
            shadow[base] = expected;
            dfp_wdata    = expected.flat;
            dfp_write    = 1'b1;
        end else begin
            dfp_read = 1'b1;
        end
        do @(negedge clk); while (!dfp_resp);
        dfp_read    = 1'b0;
        dfp_write   = 1'b0;
        actual.flat = dfp_rdata;
        if (row.op == OP_READ) begin
            expected = shadow.exists(base) ? shadow[base] : fill_pattern(base);
            check_line(row.name, expected, actual);
        end
        repeat (2) @(negedge clk);  // Past the recovery cycle.
        check_count({row.name, " responses"}, 1, resp_count - resp_before);
        check_count({row.name, " assertions"}, 0, cache_line_adapter_inst.chk_inst.error_count);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (!rst && dfp_resp) begin
            resp_count <= resp_count + 1;
        end
        if (!rst && (dfp_resp || bmem_read || bmem_write)) begin
            strobe_count <= strobe_count + 1;
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: no response arrived within %0d cycles", TIMEOUT_CYCLES);
            end_with_failure();
        end
    end

    initial begin
        line_u zero_line;
        line_u idle_line;
        zero_line = '0;
        rst       = 1'b1;
        dfp_addr  = '0;
        dfp_read  = 1'b0;
        dfp_write = 1'b0;
        dfp_wdata = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (6) @(negedge clk);  // No requests yet.
        idle_line.flat = dfp_rdata;
        check_count("idle strobes", 0, strobe_count);
        check_line("idle rdata", zero_line, idle_line);
        foreach (stimulus[i]) begin
            run_row(stimulus[i]);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/cache_line_adapter_chk.sv
`timescale 1ns/10ps
`default_nettype none

module cache_line_adapter_chk (
    input logic                            clk,
    input logic                            rst,
    input logic                            dfp_resp,
    input logic                            bmem_read,
    input logic                            bmem_write,
    input logic [line_pkg::ADDR_WIDTH-1:0] bmem_addr
);
    import line_pkg::*;

    int error_count = 0;

    strobes_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(bmem_read && bmem_write)
    ) else begin
        error_count++;
        $error("bmem_read and bmem_write are high together");
    end

    resp_single_cycle: assert property (
        @(posedge clk) disable iff (rst) dfp_resp |=> !dfp_resp
    ) else begin
        error_count++;
        $error("dfp_resp stayed high for two cycles");
    end

    addr_aligned: assert property (
        @(posedge clk) disable iff (rst)
        (bmem_read || bmem_write) |-> (bmem_addr[OFFSET_BITS-1:0] == '0)
    ) else begin
        error_count++;
        $error("bmem_addr is not line aligned during a burst");
    end

    // First edge of reset only clears the flops.
    quiet_in_reset: assert property (
        @(posedge clk) (rst && $past(rst)) |-> !(bmem_read || bmem_write)
    ) else begin
        error_count++;
        $error("memory strobe high during reset");
    end

endmodule

`default_nettype wire

//--- verif/burst_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module burst_mem_model (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [line_pkg::ADDR_WIDTH-1:0] bmem_addr,
    input  logic                            bmem_read,
    input  logic                            bmem_write,
    input  logic [line_pkg::BEAT_WIDTH-1:0] bmem_wdata,
    output logic                            bmem_ready,
    output logic [line_pkg::ADDR_WIDTH-1:0] bmem_raddr,
    output logic [line_pkg::BEAT_WIDTH-1:0] bmem_rdata,
    output logic                            bmem_rvalid
);
    import line_pkg::*;

    logic [BEAT_WIDTH-1:0] mem [logic [ADDR_WIDTH-1:0]];  // Beats by byte address.
    logic [31:0]           rand_state = 32'he103;
    logic [ADDR_WIDTH-1:0] rd_base;
    int                    rd_index;
    bit                    rd_active;
    int                    wr_index;

    function automatic logic [31:0] shuffle(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [BEAT_WIDTH-1:0] stored_beat(input logic [ADDR_WIDTH-1:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return BEAT_WIDTH'(addr);  // Untouched beats hold their own address.
    endfunction

    initial begin
        bmem_ready  = 1'b0;
        bmem_rvalid = 1'b0;
        bmem_raddr  = '0;
        bmem_rdata  = '0;
    end

    // Outputs change on the falling edge and are steady at the rising edge.
    always @(negedge clk) begin
        rand_state = shuffle(rand_state);
        if (rst) begin
            bmem_ready  = 1'b0;
            bmem_rvalid = 1'b0;
            rd_active   = 1'b0;
            wr_index    = 0;
        end else begin
            bmem_ready = (rand_state[1:0] != 2'b00);
            if (bmem_write && bmem_ready) begin
                mem[bmem_addr + ADDR_WIDTH'(wr_index * BEAT_BYTES)] = bmem_wdata;
                wr_index = wr_index + 1;  // Taken at the coming rising edge.
            end else if (!bmem_write) begin
                wr_index = 0;
            end
            bmem_rvalid = 1'b0;
            if (bmem_read) begin
                rd_base   = bmem_addr;
                rd_index  = 0;
                rd_active = 1'b1;
            end else if (rd_active && rand_state[3:2] == 2'b01) begin
                bmem_rvalid = 1'b1;  // Stray beat tagged with the next line.
                bmem_raddr  = rd_base + ADDR_WIDTH'(rd_index * BEAT_BYTES + 32);
                bmem_rdata  = {rand_state, ~rand_state};
            end else if (rd_active && rand_state[3:2] != 2'b00) begin
                bmem_rvalid = 1'b1;
                bmem_raddr  = rd_base + ADDR_WIDTH'(rd_index * BEAT_BYTES);
                bmem_rdata  = stored_beat(bmem_raddr);
                rd_index    = rd_index + 1;
                rd_active   = (rd_index < BEATS_PER_LINE);
            end
        end
    end

endmodule

`default_nettype wire

//--- source/cache_line_adapter.sv
`timescale 1ns/10ps
`default_nettype none

module cache_line_adapter (
    input  logic                            clk,
    input  logic                            rst,

    // Cache side.
    input  logic [line_pkg::ADDR_WIDTH-1:0] dfp_addr,
    input  logic                            dfp_read,
    input  logic                            dfp_write,
    input  logic [line_pkg::LINE_WIDTH-1:0] dfp_wdata,
    output logic [line_pkg::LINE_WIDTH-1:0] dfp_rdata,
    output logic                            dfp_resp,

    // Burst memory side.
    output logic [line_pkg::ADDR_WIDTH-1:0] bmem_addr,
    output logic                            bmem_read,
    output logic                            bmem_write,
    output logic [line_pkg::BEAT_WIDTH-1:0] bmem_wdata,
    input  logic                            bmem_ready,
    input  logic [line_pkg::ADDR_WIDTH-1:0] bmem_raddr,
    input  logic [line_pkg::BEAT_WIDTH-1:0] bmem_rdata,
    input  logic                            bmem_rvalid
);
    import line_pkg::*;

    line_u wdata_line;
    line_u rdata_line;

    xfer_if xfer ();

    assign wdata_line.flat = dfp_wdata;
    assign dfp_rdata       = rdata_line.flat;
    assign bmem_addr       = xfer.line_addr;  // Line base for the whole burst.

    burst_sequencer burst_sequencer_inst (
        .clk       (clk),
        .rst       (rst),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .bmem_read (bmem_read),
        .dfp_resp  (dfp_resp),
        .xfer      (xfer.seq)
    );

    line_fill line_fill_inst (
        .clk         (clk),
        .rst         (rst),
        .bmem_rvalid (bmem_rvalid),
        .bmem_raddr  (bmem_raddr),
        .bmem_rdata  (bmem_rdata),
        .dfp_rdata   (rdata_line),
        .xfer        (xfer.fill)
    );

    line_drain line_drain_inst (
        .clk        (clk),
        .rst        (rst),
        .dfp_wdata  (wdata_line),
        .bmem_ready (bmem_ready),
        .bmem_write (bmem_write),
        .bmem_wdata (bmem_wdata),
        .xfer       (xfer.drain)
    );

endmodule

`default_nettype wire

//--- source/line_drain.sv
`timescale 1ns/10ps
`default_nettype none

module line_drain (
    input  logic                            clk,
    input  logic                            rst,
    input  line_pkg::line_u                 dfp_wdata,
    input  logic                            bmem_ready,
    output logic                            bmem_write,
    output logic [line_pkg::BEAT_WIDTH-1:0] bmem_wdata,
    xfer_if.drain                           xfer
);
    import line_pkg::*;

    logic [COUNT_BITS-1:0] beat_count;
    logic                  accept;
    logic                  last;

    assign accept = xfer.drain_en && bmem_ready;
    assign last   = accept && (beat_count == LAST_BEAT);

    // Beat held steady while memory stalls.
    assign bmem_write = xfer.drain_en;
    assign bmem_wdata = dfp_wdata.beat[beat_count];

    assign xfer.drain_done = last;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_count <= '0;
        end else if (!xfer.drain_en) begin
            beat_count <= '0;
        end else if (accept) begin
            beat_count <= beat_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/line_fill.sv
`timescale 1ns/10ps
`default_nettype none

module line_fill (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            bmem_rvalid,
    input  logic [line_pkg::ADDR_WIDTH-1:0] bmem_raddr,
    input  logic [line_pkg::BEAT_WIDTH-1:0] bmem_rdata,
    output line_pkg::line_u                 dfp_rdata,
    xfer_if.fill                            xfer
);
    import line_pkg::*;

    logic [COUNT_BITS-1:0] beat_count;
    logic                  armed;
    logic [ADDR_WIDTH-1:0] expected_addr;
    logic                  take;
    logic                  last;
    line_u                 accum;
    line_u                 line_next;

    // Tag the next beat must carry.
    assign expected_addr = xfer.line_addr
                         + ADDR_WIDTH'(beat_count) * ADDR_WIDTH'(BEAT_BYTES);

    assign take = armed && bmem_rvalid && (bmem_raddr == expected_addr);
    assign last = take && (beat_count == LAST_BEAT);

    assign xfer.fill_done = last;

    always_comb begin
        line_next                  = accum;
        line_next.beat[beat_count] = bmem_rdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            armed      <= 1'b0;
            beat_count <= '0;
            dfp_rdata  <= '0;
        end else if (xfer.fill_arm) begin
            armed      <= 1'b1;
            beat_count <= '0;
        end else if (take) begin
            beat_count <= beat_count + 1'b1;  // Wraps to zero after the last beat.
            if (last) begin
                armed     <= 1'b0;
                dfp_rdata <= line_next;  // Held until the next read completes.
            end
        end
    end

    // Stray beats never reach the accumulator.
    always_ff @(posedge clk) begin
        if (take) begin
            accum <= line_next;
        end
    end

endmodule

`default_nettype wire

//--- source/burst_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module burst_sequencer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [line_pkg::ADDR_WIDTH-1:0] dfp_addr,
    input  logic                            dfp_read,
    input  logic                            dfp_write,
    output logic                            bmem_read,
    output logic                            dfp_resp,
    xfer_if.seq                             xfer
);
    import line_pkg::*;

    logic [STATE_BITS-1:0] state;
    logic [ADDR_WIDTH-1:0] line_addr;
    logic                  drain_en;
    logic                  start;

    // A new request is only taken in idle.
    assign start = (state == SEQ_IDLE) && (dfp_read || dfp_write);

    assign xfer.line_addr = line_addr;
    assign xfer.fill_arm  = bmem_read;  // Fill restarts with each burst.
    assign xfer.drain_en  = drain_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= SEQ_IDLE;
            bmem_read <= 1'b0;
            dfp_resp  <= 1'b0;
            drain_en  <= 1'b0;
        end else begin
            bmem_read <= 1'b0;
            dfp_resp  <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (dfp_read) begin
                        bmem_read <= 1'b1;  // Single-cycle burst request.
                        state     <= SEQ_READ;
                    end else if (dfp_write) begin
                        drain_en <= 1'b1;
                        state    <= SEQ_WRITE;
                    end
                end
                SEQ_READ: begin
                    if (xfer.fill_done) begin
                        dfp_resp <= 1'b1;
                        state    <= SEQ_RECOVER;
                    end
                end
                SEQ_WRITE: begin
                    if (xfer.drain_done) begin
                        drain_en <= 1'b0;
                        dfp_resp <= 1'b1;
                        state    <= SEQ_RECOVER;
                    end
                end
                SEQ_RECOVER: begin
                    // Cache drops its request while we sit here.
                    state <= SEQ_IDLE;
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // Low offset bits are ignored.
    always_ff @(posedge clk) begin
        if (start) begin
            line_addr <= {dfp_addr[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        end
    end

endmodule

`default_nettype wire

//--- source/xfer_if.sv
`timescale 1ns/10ps
`default_nettype none

interface xfer_if;
    import line_pkg::*;

    logic [ADDR_WIDTH-1:0] line_addr;   // Aligned base of the current line.
    logic                  fill_arm;
    logic                  drain_en;
    logic                  fill_done;
    logic                  drain_done;

    modport seq (
        output line_addr,
        output fill_arm,
        output drain_en,
        input  fill_done,
        input  drain_done
    );

    // Read side.
    modport fill (
        input  line_addr,
        input  fill_arm,
        output fill_done
    );

    modport drain (
        input  drain_en,
        output drain_done
    );

endinterface

`default_nettype wire

//--- source/line_pkg.sv
`default_nettype none

package line_pkg;

    localparam int unsigned ADDR_WIDTH     = 32;
    localparam int unsigned BEAT_WIDTH     = 64;
    localparam int unsigned BEATS_PER_LINE = 4;
    localparam int unsigned LINE_WIDTH     = BEAT_WIDTH * BEATS_PER_LINE;
    localparam int unsigned BEAT_BYTES     = BEAT_WIDTH / 8;
    localparam int unsigned OFFSET_BITS    = 5;   // Byte offset inside a line.
    localparam int unsigned COUNT_BITS     = $clog2(BEATS_PER_LINE);
    localparam logic [COUNT_BITS-1:0] LAST_BEAT = COUNT_BITS'(BEATS_PER_LINE - 1);

    // Sequencer state codes.
    localparam int unsigned STATE_BITS = 2;
    localparam logic [STATE_BITS-1:0] SEQ_IDLE    = 2'd0;
    localparam logic [STATE_BITS-1:0] SEQ_READ    = 2'd1;
    localparam logic [STATE_BITS-1:0] SEQ_WRITE   = 2'd2;
    localparam logic [STATE_BITS-1:0] SEQ_RECOVER = 2'd3;

    // Cache line as the cache sees it, or as memory beats.
    typedef union packed {
        logic [LINE_WIDTH-1:0]                      flat;
        logic [BEATS_PER_LINE-1:0][BEAT_WIDTH-1:0]  beat;  // Beat 0 in the low bits.
    } line_u;

endpackage

`default_nettype wire
